// File: test/alu_tests.txt
// Kind first, 1 for a program word and 2 for an expected retire in program order
// Then the destination register, then the word or the retired value
1_00_12300093 // addi x1, x0, 0x123
2_01_00000123
1_00_FFB00113 // addi x2, x0, -5
2_02_FFFFFFFB
1_00_800001B7 // lui x3, 0x80000
2_03_80000000
1_00_7F006213 // ori x4, x0, 0x7f0
2_04_000007F0
1_00_0F014293 // xori x5, x2, 0xf0
2_05_FFFFFF0B
1_00_0FF17313 // andi x6, x2, 0xff
2_06_000000FB
1_00_00012393 // slti x7, x2, 0
2_07_00000001
1_00_FFF13413 // sltiu x8, x2, -1
2_08_00000001
1_00_00409493 // slli x9, x1, 4
2_09_00001230
1_00_0081D513 // srli x10, x3, 8
2_0A_00800000
1_00_4081D593 // srai x11, x3, 8
2_0B_FF800000
1_00_00208633 // add x12, x1, x2
2_0C_0000011E
1_00_402086B3 // sub x13, x1, x2
2_0D_00000128
1_00_0040F733 // and x14, x1, x4
2_0E_00000120
1_00_0040E7B3 // or x15, x1, x4
2_0F_000007F3
1_00_0040C833 // xor x16, x1, x4
2_10_000006D3
1_00_009098B3 // sll x17, x1, x9
2_11_01230000
1_00_0071D933 // srl x18, x3, x7
2_12_40000000
1_00_4071D9B3 // sra x19, x3, x7
2_13_C0000000
1_00_00112A33 // slt x20, x2, x1
2_14_00000001
1_00_00113AB3 // sltu x21, x2, x1
2_15_00000000
1_00_007A8B13 // addi x22, x21, 7
2_16_00000007
1_00_016B0B33 // add x22, x22, x22
2_16_0000000E
1_00_401B0BB3 // sub x23, x22, x1
2_17_FFFFFEEB
1_00_404BDC13 // srai x24, x23, 4
2_18_FFFFFFEE
1_00_017C4CB3 // xor x25, x24, x23
2_19_00000105
1_00_05508013 // addi x0, x1, 0x55
2_00_00000000
1_00_00208033 // add x0, x1, x2
2_00_00000000
1_00_00100D33 // add x26, x0, x1
2_1A_00000123

// File: sim.f
common/procyon_pkg.sv
rtl/procyon_fetch.sv
rtl/procyon_dispatch.sv
rtl/procyon_regmap.sv
rob/procyon_rob.sv
ieu/procyon_rs.sv
ieu/procyon_ieu.sv
rtl/procyon.sv
test/procyon_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module procyon_tb > sim.log 2>&1 \
    && ./obj_dir/Vprocyon_tb >> sim.log 2>&1 \
    || echo "Build or simulation stopped with an error" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0

// File: test/procyon_tb.sv
`timescale 1ns/1ps

module procyon_tb
    import procyon_pkg::*;
();

    localparam int    ITEM_COUNT     = 128;
    localparam int    RETIRE_TIMEOUT = 200;
    localparam insn_t NOP            = 32'h0000_0013;

    logic     clk;
    logic     rst;
    logic     ic_valid;
    insn_t    ic_insn;
    logic     ic_en;
    addr_t    ic_pc;
    logic     retire_en;
    reg_idx_t retire_rdest;
    data_t    retire_data;

    // Kind in [43:40], register in [39:32], word or value in [31:0]
    logic [43:0] items [ITEM_COUNT];
    insn_t       imem [ITEM_COUNT];
    int          insn_count;
    reg_idx_t    exp_rdest [$];
    data_t       exp_data [$];
    int          expected_total;
    int          checked;
    int          err_count;
    int          timeout_count;
    logic        hung;

    procyon dut_i (
        .clk(clk),
        .i_rst(rst),
        .i_ic_valid(ic_valid),
        .i_ic_insn(ic_insn),
        .o_ic_en(ic_en),
        .o_ic_pc(ic_pc),
        .o_retire_en(retire_en),
        .o_retire_rdest(retire_rdest),
        .o_retire_data(retire_data)
    );

    always #50 clk = ~clk;

    function automatic insn_t word_at(addr_t pc);
        int idx;
        idx = int'(pc / addr_t'(PC_STEP));
        if (idx < insn_count) begin
            return imem[idx];
        end
        return NOP;
    endfunction

    // Instruction port with random gaps in the stream
    initial begin
        void'($urandom(32'hd140));
        forever begin
            @(posedge clk);
            #1;
            ic_valid = ($urandom_range(3, 0) != 0);
            ic_insn  = word_at(ic_pc);
        end
    end

    task automatic load_tests();
        for (int i = 0; i < ITEM_COUNT; i++) begin
            items[i] = '0;
        end
        $readmemh("test/alu_tests.txt", items);
        for (int i = 0; i < ITEM_COUNT; i++) begin
            if (items[i][43:40] == 4'h1) begin
                imem[insn_count] = items[i][31:0];
                insn_count++;
            end else if (items[i][43:40] == 4'h2) begin
                exp_rdest.push_back(reg_idx_t'(items[i][36:32]));
                exp_data.push_back(items[i][31:0]);
            end
        end
        expected_total = exp_rdest.size();
    endtask

    task automatic check_reset_state(input string when);
        if (retire_en !== 1'b0) begin
            $display("Fail at %0t ns: retire enable is not low %s", $time, when);
            err_count++;
        end
        if (ic_en !== 1'b1) begin
            $display("Fail at %0t ns: fetch enable is not high %s", $time, when);
            err_count++;
        end
        if (ic_pc !== '0) begin
            $display("Fail at %0t ns: fetch PC is %h %s", $time, ic_pc, when);
            err_count++;
        end
    endtask

    task automatic check_rdest(input reg_idx_t expected);
        int cycles;
        cycles = 0;
        while (retire_en !== 1'b1 && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (retire_en !== 1'b1) begin
            $display("No retire %0d came within %0d cycles", checked, cycles);
            timeout_count++;
            hung = 1'b1;
        end else if (retire_rdest !== expected) begin
            $display("Fail at %0t ns: retire %0d wrote x%0d, expected x%0d",
                     $time, checked, retire_rdest, expected);
            err_count++;
        end
    endtask

    task automatic check_data(input data_t expected);
        int cycles;
        cycles = 0;
        while (retire_en !== 1'b1 && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (retire_en !== 1'b1) begin
            $display("No retire data %0d came within %0d cycles", checked, cycles);
            timeout_count++;
            hung = 1'b1;
        end else if (retire_data !== expected) begin
            $display("Fail at %0t ns: retire %0d data %h, expected %h",
                     $time, checked, retire_data, expected);
            err_count++;
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        ic_valid      = 1'b0;
        ic_insn       = NOP;
        insn_count    = 0;
        checked       = 0;
        err_count     = 0;
        timeout_count = 0;
        hung          = 1'b0;
        load_tests();
        if (expected_total == 0) begin
            $display("No expected retires were read from test/alu_tests.txt");
        end

        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #1;
            check_reset_state("during reset");
        end
        rst = 1'b0;
        @(negedge clk);
        check_reset_state("at reset release");

        // Retires past the end of the list are program padding
        while (exp_rdest.size() != 0 && !hung) begin
            check_rdest(exp_rdest.pop_front());
            if (hung) begin
                break;
            end
            check_data(exp_data.pop_front());
            checked++;
            @(negedge clk);
        end

        $display("Retires checked %0d of %0d, wrong values %0d, timeouts %0d",
                 checked, expected_total, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0 && expected_total != 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/procyon.sv
`timescale 1ns/1ps

module procyon
    import procyon_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst,

    input  logic     i_ic_valid,
    input  insn_t    i_ic_insn,
    output logic     o_ic_en,
    output addr_t    o_ic_pc,

    output logic     o_retire_en,
    output reg_idx_t o_retire_rdest,
    output data_t    o_retire_data
);

    logic     fetch_valid;
    insn_t    fetch_insn;
    logic     dispatch_ready;

    reg_idx_t lookup_rsrc_a;
    reg_idx_t lookup_rsrc_b;
    operand_t regmap_lookup_a;
    operand_t regmap_lookup_b;
    operand_t rob_src_a;
    operand_t rob_src_b;

    logic     rob_full;
    logic     rs_full;
    rob_tag_t tail_tag;
    logic     enq_en;
    decoded_t decoded;

    logic     issue_valid;
    issue_t   issue;
    cdb_t     cdb;
    retire_t  retire;

    assign o_retire_en    = retire.en;
    assign o_retire_rdest = retire.rdest;
    assign o_retire_data  = retire.data;

    procyon_fetch procyon_fetch_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_ic_valid(i_ic_valid),
        .i_ic_insn(i_ic_insn),
        .o_ic_en(o_ic_en),
        .o_ic_pc(o_ic_pc),
        .i_ready(dispatch_ready),
        .o_valid(fetch_valid),
        .o_insn(fetch_insn)
    );

    procyon_dispatch procyon_dispatch_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_valid(fetch_valid),
        .i_insn(fetch_insn),
        .o_ready(dispatch_ready),
        .o_lookup_rsrc_a(lookup_rsrc_a),
        .o_lookup_rsrc_b(lookup_rsrc_b),
        .i_rob_full(rob_full),
        .i_rs_full(rs_full),
        .i_tail_tag(tail_tag),
        .o_enq_en(enq_en),
        .o_decoded(decoded)
    );

    procyon_regmap procyon_regmap_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_lookup_rsrc_a(lookup_rsrc_a),
        .i_lookup_rsrc_b(lookup_rsrc_b),
        .o_lookup_a(regmap_lookup_a),
        .o_lookup_b(regmap_lookup_b),
        .i_rename_en(enq_en),
        .i_rename_rdest(decoded.rdest),
        .i_rename_tag(tail_tag),
        .i_retire(retire)
    );

    procyon_rob procyon_rob_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_enq_en(enq_en),
        .i_enq_rdest(decoded.rdest),
        .o_tail_tag(tail_tag),
        .o_full(rob_full),
        .i_lookup_a(regmap_lookup_a),
        .i_lookup_b(regmap_lookup_b),
        .o_src_a(rob_src_a),
        .o_src_b(rob_src_b),
        .i_cdb(cdb),
        .o_retire(retire)
    );

    procyon_rs procyon_rs_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_en(enq_en),
        .i_decoded(decoded),
        .i_src_a(rob_src_a),
        .i_src_b(rob_src_b),
        .i_dst_tag(tail_tag),
        .i_cdb(cdb),
        .o_full(rs_full),
        .o_issue_valid(issue_valid),
        .o_issue(issue)
    );

    procyon_ieu procyon_ieu_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_issue_valid(issue_valid),
        .i_issue(issue),
        .o_cdb(cdb)
    );

endmodule

// File: ieu/procyon_ieu.sv
`timescale 1ns/1ps

module procyon_ieu
    import procyon_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst,

    input  logic   i_issue_valid,
    input  issue_t i_issue,

    output cdb_t   o_cdb
);

    data_t      src_a;
    data_t      src_b;
    logic [4:0] shamt;
    data_t      result;

    assign src_a = i_issue.src_a;
    assign src_b = i_issue.src_b;
    assign shamt = src_b[4:0];

    always_comb begin
        case (i_issue.op)
            ALU_ADD:  result = src_a + src_b;
            ALU_SUB:  result = src_a - src_b;
            ALU_AND:  result = src_a & src_b;
            ALU_OR:   result = src_a | src_b;
            ALU_XOR:  result = src_a ^ src_b;
            ALU_SLL:  result = src_a << shamt;
            ALU_SRL:  result = src_a >> shamt;
            ALU_SRA:  result = data_t'($signed(src_a) >>> shamt);
            ALU_SLT:  result = data_t'($signed(src_a) < $signed(src_b));
            ALU_SLTU: result = data_t'(src_a < src_b);
            default:  result = '0;
        endcase
    end

    // Result goes out on the CDB the cycle after issue
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_cdb.en <= 1'b0;
        end else begin
            o_cdb.en <= i_issue_valid;
        end
        o_cdb.tag  <= i_issue.tag;
        o_cdb.data <= result;
    end

endmodule

// File: ieu/procyon_rs.sv
`timescale 1ns/1ps

module procyon_rs
    import procyon_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst,

    input  logic     i_en,
    input  decoded_t i_decoded,
    input  operand_t i_src_a,
    input  operand_t i_src_b,
    input  rob_tag_t i_dst_tag,
    input  cdb_t     i_cdb,
    output logic     o_full,

    output logic     o_issue_valid,
    output issue_t   o_issue
);

    typedef logic [$clog2(RS_DEPTH)-1:0] slot_idx_t;

    logic [RS_DEPTH-1:0] slot_valid;
    alu_op_e             slot_op  [RS_DEPTH];
    operand_t            slot_a   [RS_DEPTH];
    operand_t            slot_b   [RS_DEPTH];
    rob_tag_t            slot_tag [RS_DEPTH];
    slot_idx_t           free_idx;
    slot_idx_t           issue_idx;
    operand_t            enq_a;
    operand_t            enq_b;

    function automatic operand_t wake(operand_t src);
        operand_t res;
        res = src;
        if (i_cdb.en && !src.rdy && src.tag == i_cdb.tag) begin
            res.rdy  = 1'b1;
            res.data = i_cdb.data;
        end
        return res;
    endfunction

    // Immediate and zero operands are ready on entry
    always_comb begin
        enq_a = i_src_a;
        enq_b = i_src_b;
        if (i_decoded.zero_a) begin
            enq_a = '{rdy: 1'b1, tag: '0, data: '0};
        end
        if (i_decoded.imm_b) begin
            enq_b = '{rdy: 1'b1, tag: '0, data: i_decoded.imm};
        end
    end

    // Lowest index wins for both allocate and issue
    always_comb begin
        free_idx      = '0;
        issue_idx     = '0;
        o_issue_valid = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_idx = slot_idx_t'(i);
            end
            if (slot_valid[i] && slot_a[i].rdy && slot_b[i].rdy) begin
                issue_idx     = slot_idx_t'(i);
                o_issue_valid = 1'b1;
            end
        end
        o_issue.op    = slot_op[issue_idx];
        o_issue.src_a = slot_a[issue_idx].data;
        o_issue.src_b = slot_b[issue_idx].data;
        o_issue.tag   = slot_tag[issue_idx];
    end

    assign o_full = &slot_valid;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            slot_valid <= '0;
        end else begin
            if (o_issue_valid) begin
                slot_valid[issue_idx] <= 1'b0;
            end
            if (i_en) begin
                slot_valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            slot_a[i] <= wake(slot_a[i]);
            slot_b[i] <= wake(slot_b[i]);
        end
        if (i_en) begin
            slot_op[free_idx]  <= i_decoded.op;
            slot_a[free_idx]   <= enq_a;
            slot_b[free_idx]   <= enq_b;
            slot_tag[free_idx] <= i_dst_tag;
        end
    end

endmodule

// File: rob/procyon_rob.sv
`timescale 1ns/1ps

module procyon_rob
    import procyon_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst,

    input  logic     i_enq_en,
    input  reg_idx_t i_enq_rdest,
    output rob_tag_t o_tail_tag,
    output logic     o_full,

    input  operand_t i_lookup_a,
    input  operand_t i_lookup_b,
    output operand_t o_src_a,
    output operand_t o_src_b,

    input  cdb_t     i_cdb,
    output retire_t  o_retire
);

    reg_idx_t                       rob_rdest [ROB_DEPTH];
    data_t                          rob_data  [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]           rob_valid;
    logic [ROB_DEPTH-1:0]           rob_done;
    rob_tag_t                       head;
    rob_tag_t                       tail;
    logic [$clog2(ROB_DEPTH+1)-1:0] count;
    logic                           retire_en;

    function automatic operand_t resolve(operand_t src);
        operand_t res;
        res = src;
        if (!src.rdy) begin
            if (rob_done[src.tag]) begin
                res.rdy  = 1'b1;
                res.data = rob_data[src.tag];
            end else if (i_cdb.en && i_cdb.tag == src.tag) begin
                res.rdy  = 1'b1;
                res.data = i_cdb.data;
            end
        end
        return res;
    endfunction

    assign o_tail_tag = tail;
    assign o_full     = (count == ROB_DEPTH);
    assign retire_en  = rob_valid[head] & rob_done[head];

    always_comb begin
        o_src_a        = resolve(i_lookup_a);
        o_src_b        = resolve(i_lookup_b);
        o_retire.en    = retire_en;
        o_retire.rdest = rob_rdest[head];
        o_retire.tag   = head;
        o_retire.data  = rob_data[head];
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            rob_valid <= '0;
            rob_done  <= '0;
        end else begin
            if (i_enq_en) begin
                rob_valid[tail] <= 1'b1;
                rob_done[tail]  <= 1'b0;
                tail            <= tail + 1'b1;
            end
            if (i_cdb.en) begin
                rob_done[i_cdb.tag] <= 1'b1;
            end
            if (retire_en) begin
                rob_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            if (i_enq_en && !retire_en) begin
                count <= count + 1'b1;
            end else if (!i_enq_en && retire_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_enq_en) begin
            rob_rdest[tail] <= i_enq_rdest;
        end
        // x0 results are dropped here so x0 retires as zero
        if (i_cdb.en) begin
            rob_data[i_cdb.tag] <= (rob_rdest[i_cdb.tag] == '0) ? '0 : i_cdb.data;
        end
    end

    assert property (@(posedge clk) disable iff (i_rst) i_enq_en |-> !o_full);
    assert property (@(posedge clk) disable iff (i_rst) i_cdb.en |-> rob_valid[i_cdb.tag]);

endmodule

// File: rtl/procyon_regmap.sv
`timescale 1ns/1ps

module procyon_regmap
    import procyon_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst,

    input  reg_idx_t i_lookup_rsrc_a,
    input  reg_idx_t i_lookup_rsrc_b,
    output operand_t o_lookup_a,
    output operand_t o_lookup_b,

    input  logic     i_rename_en,
    input  reg_idx_t i_rename_rdest,
    input  rob_tag_t i_rename_tag,

    input  retire_t  i_retire
);

    data_t    regs_data [REG_COUNT];
    rob_tag_t regs_tag  [REG_COUNT];
    logic     regs_rdy  [REG_COUNT];

    function automatic operand_t lookup(reg_idx_t idx);
        operand_t res;
        res.rdy  = regs_rdy[idx];
        res.tag  = regs_tag[idx];
        res.data = regs_data[idx];
        // Bypass a retire of the pending producer
        if (i_retire.en && i_retire.rdest == idx && i_retire.tag == regs_tag[idx]) begin
            res.rdy  = 1'b1;
            res.data = i_retire.data;
        end
        if (idx == '0) begin
            res.rdy  = 1'b1;
            res.data = '0;
        end
        return res;
    endfunction

    always_comb begin
        o_lookup_a = lookup(i_lookup_rsrc_a);
        o_lookup_b = lookup(i_lookup_rsrc_b);
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_data[i] <= '0;
                regs_tag[i]  <= '0;
                regs_rdy[i]  <= 1'b1;
            end
        end else begin
            if (i_retire.en && i_retire.rdest != '0) begin
                regs_data[i_retire.rdest] <= i_retire.data;
                if (regs_tag[i_retire.rdest] == i_retire.tag) begin
                    regs_rdy[i_retire.rdest] <= 1'b1;
                end
            end
            // A rename in the same cycle overrides the retire
            if (i_rename_en && i_rename_rdest != '0) begin
                regs_rdy[i_rename_rdest] <= 1'b0;
                regs_tag[i_rename_rdest] <= i_rename_tag;
            end
        end
    end

endmodule

// File: rtl/procyon_dispatch.sv
`timescale 1ns/1ps

module procyon_dispatch
    import procyon_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst,

    input  logic     i_valid,
    input  insn_t    i_insn,
    output logic     o_ready,

    output reg_idx_t o_lookup_rsrc_a,
    output reg_idx_t o_lookup_rsrc_b,

    input  logic     i_rob_full,
    input  logic     i_rs_full,
    input  rob_tag_t i_tail_tag,
    output logic     o_enq_en,
    output decoded_t o_decoded
);

    logic [6:0] opcode;
    decoded_t   dec;
    decoded_t   decoded_q;
    logic       valid_q;

    assign opcode = i_insn[6:0];

    always_comb begin
        dec.rsrc_a = i_insn[19:15];
        dec.rsrc_b = i_insn[24:20];
        dec.rdest  = i_insn[11:7];
        dec.imm    = data_t'({{20{i_insn[31]}}, i_insn[31:20]});
        dec.imm_b  = (opcode != OPC_OP);
        dec.zero_a = 1'b0;
        case (i_insn[14:12])
            3'b000:  dec.op = (opcode == OPC_OP && i_insn[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  dec.op = ALU_SLL;
            3'b010:  dec.op = ALU_SLT;
            3'b011:  dec.op = ALU_SLTU;
            3'b100:  dec.op = ALU_XOR;
            3'b101:  dec.op = i_insn[30] ? ALU_SRA : ALU_SRL;
            3'b110:  dec.op = ALU_OR;
            default: dec.op = ALU_AND;
        endcase
        // LUI is an add of the upper immediate to zero
        if (opcode == OPC_LUI) begin
            dec.op     = ALU_ADD;
            dec.imm    = {i_insn[31:12], 12'b0};
            dec.zero_a = 1'b1;
        end
    end

    assign o_enq_en        = valid_q & ~i_rob_full & ~i_rs_full;
    assign o_ready         = ~valid_q | o_enq_en;
    assign o_decoded       = decoded_q;
    assign o_lookup_rsrc_a = decoded_q.rsrc_a;
    assign o_lookup_rsrc_b = decoded_q.rsrc_b;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else if (o_ready) begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid && o_ready) begin
            decoded_q <= dec;
        end
    end

    // Back to back enqueues must get consecutive ROB tags
    assert property (@(posedge clk) disable iff (i_rst)
        o_enq_en ##1 o_enq_en |-> i_tail_tag == rob_tag_t'($past(i_tail_tag) + 1'b1));

endmodule

// File: rtl/procyon_fetch.sv
`timescale 1ns/1ps

module procyon_fetch
    import procyon_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst,

    input  logic  i_ic_valid,
    input  insn_t i_ic_insn,
    output logic  o_ic_en,
    output addr_t o_ic_pc,

    input  logic  i_ready,
    output logic  o_valid,
    output insn_t o_insn
);

    insn_t                            queue [FETCH_DEPTH];
    logic [$clog2(FETCH_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FETCH_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(FETCH_DEPTH+1)-1:0] count;
    logic [$clog2(FETCH_DEPTH+1)-1:0] count_next;
    logic                             push;
    logic                             pop;

    assign push    = o_ic_en & i_ic_valid;
    assign pop     = o_valid & i_ready;
    assign o_valid = (count != '0);
    assign o_insn  = queue[rd_ptr];

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (!push && pop) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_ic_pc <= '0;
            o_ic_en <= 1'b1;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
        end else begin
            if (push) begin
                o_ic_pc <= o_ic_pc + addr_t'(PC_STEP);
                wr_ptr  <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count   <= count_next;
            // Stop requesting once the last slot is taken
            o_ic_en <= (count_next != FETCH_DEPTH);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= i_ic_insn;
        end
    end

    assert property (@(posedge clk) disable iff (i_rst) push |-> count != FETCH_DEPTH);

endmodule

// File: common/procyon_pkg.sv
package procyon_pkg;

    localparam int DATA_WIDTH  = 32;
    localparam int ADDR_WIDTH  = 32;
    localparam int REG_COUNT   = 32;
    localparam int ROB_DEPTH   = 16;
    localparam int RS_DEPTH    = 4;
    localparam int FETCH_DEPTH = 4;
    localparam int PC_STEP     = 4;

    // RV32I major opcodes that the core decodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    typedef logic [DATA_WIDTH-1:0]        data_t;
    typedef logic [ADDR_WIDTH-1:0]        addr_t;
    typedef logic [31:0]                  insn_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef struct packed {
        alu_op_e  op;
        reg_idx_t rsrc_a;
        reg_idx_t rsrc_b;
        reg_idx_t rdest;
        data_t    imm;
        logic     imm_b;
        logic     zero_a;
    } decoded_t;

    typedef struct packed {
        logic     rdy;
        rob_tag_t tag;
        data_t    data;
    } operand_t;

    typedef struct packed {
        alu_op_e  op;
        data_t    src_a;
        data_t    src_b;
        rob_tag_t tag;
    } issue_t;

    typedef struct packed {
        logic     en;
        rob_tag_t tag;
        data_t    data;
    } cdb_t;

    typedef struct packed {
        logic     en;
        reg_idx_t rdest;
        rob_tag_t tag;
        data_t    data;
    } retire_t;

endpackage
